/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= compile.f
TB_TOP     ?= fc_tb
RTL_TOP    ?= fc_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing
LINT_FLAGS ?= -Wall

BIN := $(OBJ_DIR)/V$(TB_TOP)
SRCS := $(wildcard hdl/*.sv) $(wildcard test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
hdl/fc_params_pkg.sv
hdl/fc_types_pkg.sv
hdl/fc_ram.sv
hdl/fc_ctrl.sv
hdl/fc_mac_core.sv
hdl/fc_serializer.sv
hdl/fc_top.sv
test/fc_clkgen.sv
test/fc_tb.sv

/* hdl/fc_ctrl.sv */
`timescale 1ns/1ps

module fc_ctrl (
  input  logic                                     clk,
  input  logic                                     xrst,
  input  fc_types_pkg::fc_ctrl_s                   in_ctrl,
  input  logic                                     req,
  input  logic [fc_params_pkg::GOBOU_CORELOG-1:0]  net_sel,
  input  logic                                     net_we,
  input  logic [fc_params_pkg::GOBOU_NETSIZE-1:0]  net_addr,
  input  logic [fc_params_pkg::MEMSIZE-1:0]        in_offset,
  input  logic [fc_params_pkg::MEMSIZE-1:0]        out_offset,
  input  logic [fc_params_pkg::GOBOU_NETSIZE-1:0]  net_offset,
  input  logic [fc_params_pkg::DWIDTHLOG-1:0]      qbits,
  input  logic [fc_params_pkg::LWIDTH-1:0]         total_out,
  input  logic [fc_params_pkg::LWIDTH-1:0]         total_in,
  input  logic                                     bias_en,
  input  logic                                     relu_en,
  input  logic signed [fc_params_pkg::DWIDTH-1:0]  out_wdata,
  output fc_types_pkg::fc_ctrl_s                   out_ctrl,
  output logic                                     ack,
  output logic                                     img_we,
  output logic [fc_params_pkg::MEMSIZE-1:0]        img_addr,
  output logic signed [fc_params_pkg::DWIDTH-1:0]  img_wdata,
  output logic [fc_params_pkg::GOBOU_CORE-1:0]     mem_net_we,
  output logic [fc_params_pkg::GOBOU_NETSIZE-1:0]  mem_net_addr,
  output logic [fc_params_pkg::DWIDTHLOG-1:0]      q_qbits,
  output logic                                     q_bias_en,
  output logic                                     q_relu_en,
  output logic                                     breg_we,
  output logic                                     serial_we
);

  fc_types_pkg::fc_state_e                 state;
  fc_types_pkg::fc_ctrl_s                  ctrl_q;
  logic                                    req_d;
  logic                                    ack_q;
  logic                                    start_req;
  logic                                    setup_end;
  logic                                    input_end;
  logic                                    output_end;
  logic                                    last_iter;
  logic [fc_params_pkg::LWIDTH-1:0]        total_in_q;
  logic [fc_params_pkg::LWIDTH-1:0]        total_out_q;
  logic [fc_params_pkg::LWIDTH-1:0]        count_in;
  logic [fc_params_pkg::LWIDTH-1:0]        count_out;
  logic [fc_params_pkg::LWIDTH-1:0]        setup_cnt;
  logic [fc_params_pkg::MEMSIZE-1:0]       in_offset_q;
  logic [fc_params_pkg::MEMSIZE-1:0]       out_offset_q;
  logic [fc_params_pkg::MEMSIZE-1:0]       img_addr_q;
  logic [fc_params_pkg::GOBOU_NETSIZE-1:0] net_addr_q;
  logic [fc_params_pkg::DWIDTHLOG-1:0]     qbits_q;
  logic                                    bias_en_q;
  logic                                    relu_en_q;
  logic                                    breg_we_q;
  logic                                    serial_we_q;
  logic                                    img_we_q;
  logic [fc_params_pkg::GOBOU_CORELOG:0]   serial_cnt;

  // ==================================================
  // sequencer
  // ==================================================

  // req only counts while idle
  assign start_req  = state == fc_types_pkg::WAIT && req && !req_d;
  assign setup_end  = state == fc_types_pkg::SETUP
                   && int'(setup_cnt) == fc_params_pkg::SETUP_TIME - 1;
  assign input_end  = state == fc_types_pkg::INPUT && count_in == total_in_q - 1'b1;
  assign output_end = state == fc_types_pkg::OUTPUT
                   && int'(serial_cnt) == fc_params_pkg::GOBOU_CORE;
  // the last write of the batch is still in flight at output_end
  assign last_iter  = int'(count_out) + 1 >= int'(total_out_q);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_d <= 1'b0;
    end else begin
      req_d <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= fc_types_pkg::WAIT;
      count_in  <= '0;
      setup_cnt <= '0;
    end else begin
      case (state)
        fc_types_pkg::WAIT: begin
          if (start_req) begin
            state <= fc_types_pkg::INPUT;
          end
        end
        fc_types_pkg::SETUP: begin
          if (setup_end) begin
            state     <= fc_types_pkg::INPUT;
            setup_cnt <= '0;
          end else begin
            setup_cnt <= setup_cnt + 1'b1;
          end
        end
        fc_types_pkg::INPUT: begin
          if (input_end) begin
            state    <= fc_types_pkg::BIAS;
            count_in <= '0;
          end else begin
            count_in <= count_in + 1'b1;
          end
        end
        fc_types_pkg::BIAS: begin
          state <= fc_types_pkg::OUTPUT;
        end
        fc_types_pkg::OUTPUT: begin
          if (output_end) begin
            state <= last_iter ? fc_types_pkg::WAIT : fc_types_pkg::SETUP;
          end
        end
        default: begin
          state <= fc_types_pkg::WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack_q <= 1'b1;
    end else if (start_req) begin
      ack_q <= 1'b0;
    end else if (output_end && last_iter) begin
      ack_q <= 1'b1;
    end
  end

  assign ack = ack_q;

  // layer parameters, held for the whole run
  always_ff @(posedge clk) begin
    if (!xrst) begin
      qbits_q      <= '0;
      bias_en_q    <= 1'b0;
      relu_en_q    <= 1'b0;
      total_in_q   <= '0;
      total_out_q  <= '0;
      in_offset_q  <= '0;
      out_offset_q <= '0;
    end else if (start_req) begin
      qbits_q      <= qbits;
      bias_en_q    <= bias_en;
      relu_en_q    <= relu_en;
      total_in_q   <= total_in;
      total_out_q  <= total_out;
      in_offset_q  <= in_offset;
      out_offset_q <= out_offset;
    end
  end

  assign q_qbits   = qbits_q;
  assign q_bias_en = bias_en_q;
  assign q_relu_en = relu_en_q;

  // ==================================================
  // strobes to the lanes and the serializer
  // ==================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ctrl_q      <= '0;
      breg_we_q   <= 1'b0;
      serial_we_q <= 1'b0;
      img_we_q    <= 1'b0;
    end else begin
      ctrl_q.start <= start_req || setup_end;
      ctrl_q.valid <= state == fc_types_pkg::INPUT;
      ctrl_q.stop  <= state == fc_types_pkg::BIAS;
      breg_we_q    <= state == fc_types_pkg::BIAS;
      // results come back with the lane start
      serial_we_q  <= in_ctrl.start;
      img_we_q     <= serial_we_q
                   || (serial_cnt != '0 && int'(serial_cnt) < fc_params_pkg::GOBOU_CORE);
    end
  end

  assign out_ctrl  = ctrl_q;
  assign breg_we   = breg_we_q;
  assign serial_we = serial_we_q;
  assign img_we    = img_we_q;
  assign img_wdata = out_wdata;

  // position within the shifted-out batch
  always_ff @(posedge clk) begin
    if (!xrst) begin
      serial_cnt <= '0;
    end else if (serial_we_q) begin
      serial_cnt <= 1;
    end else if (int'(serial_cnt) == fc_params_pkg::GOBOU_CORE) begin
      serial_cnt <= '0;
    end else if (serial_cnt != '0) begin
      serial_cnt <= serial_cnt + 1'b1;
    end
  end

  // output pointer, one step per image write
  always_ff @(posedge clk) begin
    if (!xrst) begin
      count_out <= '0;
    end else if (start_req) begin
      count_out <= '0;
    end else if (img_we_q) begin
      count_out <= count_out + 1'b1;
    end
  end

  // ==================================================
  // address generation
  // ==================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_addr_q <= '0;
    end else if (start_req) begin
      img_addr_q <= in_offset;
    end else if (output_end) begin
      img_addr_q <= in_offset_q;
    end else if (serial_we_q) begin
      img_addr_q <= out_offset_q + count_out;
    end else if (state == fc_types_pkg::INPUT || img_we_q) begin
      img_addr_q <= img_addr_q + 1'b1;
    end
  end

  assign img_addr = img_addr_q;

  // runs on through consecutive weight blocks, bias word last
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_addr_q <= '0;
    end else if (start_req) begin
      net_addr_q <= net_offset;
    end else if (state == fc_types_pkg::INPUT || state == fc_types_pkg::BIAS) begin
      net_addr_q <= net_addr_q + 1'b1;
    end
  end

  // host load takes the weight address
  assign mem_net_addr = net_we ? net_addr : net_addr_q;

  for (genvar c = 0; c < fc_params_pkg::GOBOU_CORE; c++) begin : g_net_we
    assign mem_net_we[c] = net_we && int'(net_sel) == c;
  end

endmodule

/* hdl/fc_mac_core.sv */
`timescale 1ns/1ps

module fc_mac_core (
  input  logic                                    clk,
  input  logic                                    xrst,
  input  fc_types_pkg::fc_ctrl_s                  ctrl_in,
  input  logic signed [fc_params_pkg::DWIDTH-1:0] x,
  input  logic signed [fc_params_pkg::DWIDTH-1:0] w,
  input  logic                                    breg_we,
  input  logic [fc_params_pkg::DWIDTHLOG-1:0]     qbits,
  input  logic                                    bias_en,
  input  logic                                    relu_en,
  output fc_types_pkg::fc_ctrl_s                  ctrl_out,
  output logic signed [fc_params_pkg::DWIDTH-1:0] result
);

  fc_types_pkg::fc_ctrl_s                                ctrl_q;
  logic signed [2*fc_params_pkg::DWIDTH-1:0]             prod;
  logic signed [fc_params_pkg::ACCWIDTH-1:0]             acc;
  logic signed [fc_params_pkg::DWIDTH-1:0]               bias;
  logic signed [fc_params_pkg::ACCWIDTH-1:0]             bias_ext;
  logic signed [fc_params_pkg::ACCWIDTH-1:0]             sum;
  logic signed [fc_params_pkg::ACCWIDTH-1:0]             act;
  logic signed [fc_params_pkg::ACCWIDTH-1:0]             act_q;
  logic signed [fc_params_pkg::ACCWIDTH-1:0]             shifted;
  logic [fc_params_pkg::ACCWIDTH-fc_params_pkg::DWIDTH:0] upper;

  // product stage with the ctrl delayed to match
  always_ff @(posedge clk) begin
    prod <= x * w;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_q.start) begin
      acc <= '0;
    end else if (ctrl_q.valid) begin
      acc <= acc + {{(fc_params_pkg::ACCWIDTH - 2*fc_params_pkg::DWIDTH)
                     {prod[2*fc_params_pkg::DWIDTH-1]}}, prod};
    end
  end

  // bias word arrives from the weight ram right after the last input
  always_ff @(posedge clk) begin
    if (breg_we) begin
      bias <= w;
    end
  end

  // ==================================================
  // bias, relu, requantize
  // ==================================================

  assign bias_ext = bias_en
                  ? {{(fc_params_pkg::ACCWIDTH - fc_params_pkg::DWIDTH)
                      {bias[fc_params_pkg::DWIDTH-1]}}, bias}
                  : '0;
  assign sum      = acc + bias_ext;
  assign act      = (relu_en && sum[fc_params_pkg::ACCWIDTH-1]) ? '0 : sum;

  always_ff @(posedge clk) begin
    if (ctrl_q.stop) begin
      act_q <= act;
    end
  end

  assign shifted = act_q >>> qbits;
  // all bits above the result's sign must equal it
  assign upper   = shifted[fc_params_pkg::ACCWIDTH-1:fc_params_pkg::DWIDTH-1];

  always_comb begin
    if (&upper || ~|upper) begin
      result = shifted[fc_params_pkg::DWIDTH-1:0];
    end else if (shifted[fc_params_pkg::ACCWIDTH-1]) begin
      result = {1'b1, {(fc_params_pkg::DWIDTH-1){1'b0}}};
    end else begin
      result = {1'b0, {(fc_params_pkg::DWIDTH-1){1'b1}}};
    end
  end

  // result ready one cycle after the activation stage
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ctrl_out <= '0;
    end else begin
      ctrl_out.start <= ctrl_q.stop;
      ctrl_out.valid <= ctrl_q.stop;
      ctrl_out.stop  <= 1'b0;
    end
  end

endmodule

/* hdl/fc_params_pkg.sv */
package fc_params_pkg;

  // ==================================================
  // lane count and word sizes
  // ==================================================

  // parallel mac lanes, and the width of a lane select
  localparam int GOBOU_CORE    = 4;
  localparam int GOBOU_CORELOG = 2;

  // data word and the quantize shift amount
  localparam int DWIDTH        = 16;
  localparam int DWIDTHLOG     = 4;

  // accumulator, wide enough for long dot products
  localparam int ACCWIDTH      = 40;

  // ==================================================
  // memories and layer counters
  // ==================================================

  // image memory address bits
  localparam int MEMSIZE       = 10;
  // weight memory address bits, one memory per lane
  localparam int GOBOU_NETSIZE = 9;
  // total_in / total_out counters
  localparam int LWIDTH        = 10;
  // idle cycles between two batches of outputs
  localparam int SETUP_TIME    = 4;

endpackage

/* hdl/fc_ram.sv */
`timescale 1ns/1ps

module fc_ram #(
  parameter int WIDTH    = fc_params_pkg::DWIDTH,
  parameter int DEPTHLOG = fc_params_pkg::MEMSIZE
) (
  input  logic                clk,
  input  logic                we,
  input  logic [DEPTHLOG-1:0] addr,
  input  logic [WIDTH-1:0]    wdata,
  output logic [WIDTH-1:0]    rdata
);

  logic [WIDTH-1:0] mem [2**DEPTHLOG];

  // read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

/* hdl/fc_serializer.sv */
`timescale 1ns/1ps

module fc_serializer (
  input  logic                                                             clk,
  input  logic                                                             xrst,
  input  logic                                                             load,
  input  logic [fc_params_pkg::GOBOU_CORE-1:0][fc_params_pkg::DWIDTH-1:0]  lane_data,
  output logic signed [fc_params_pkg::DWIDTH-1:0]                          out_wdata
);

  logic [fc_params_pkg::GOBOU_CORE-1:0][fc_params_pkg::DWIDTH-1:0] shreg;

  // lanes move down toward lane 0, zeros fill from the top
  always_ff @(posedge clk) begin
    if (!xrst) begin
      shreg <= '0;
    end else if (load) begin
      shreg <= lane_data;
    end else begin
      shreg <= {{fc_params_pkg::DWIDTH{1'b0}}, shreg[fc_params_pkg::GOBOU_CORE-1:1]};
    end
  end

  assign out_wdata = shreg[0];

endmodule

/* hdl/fc_top.sv */
`timescale 1ns/1ps

module fc_top (
  input  logic                                    clk,
  input  logic                                    xrst,
  input  logic                                    host_img_we,
  input  logic [fc_params_pkg::MEMSIZE-1:0]       host_img_addr,
  input  logic [fc_params_pkg::DWIDTH-1:0]        host_img_wdata,
  output logic [fc_params_pkg::DWIDTH-1:0]        host_img_rdata,
  input  logic                                    net_we,
  input  logic [fc_params_pkg::GOBOU_CORELOG-1:0] net_sel,
  input  logic [fc_params_pkg::GOBOU_NETSIZE-1:0] net_addr,
  input  logic [fc_params_pkg::DWIDTH-1:0]        net_wdata,
  input  logic [fc_params_pkg::MEMSIZE-1:0]       in_offset,
  input  logic [fc_params_pkg::MEMSIZE-1:0]       out_offset,
  input  logic [fc_params_pkg::GOBOU_NETSIZE-1:0] net_offset,
  input  logic [fc_params_pkg::DWIDTHLOG-1:0]     qbits,
  input  logic [fc_params_pkg::LWIDTH-1:0]        total_in,
  input  logic [fc_params_pkg::LWIDTH-1:0]        total_out,
  input  logic                                    bias_en,
  input  logic                                    relu_en,
  input  logic                                    req,
  output logic                                    ack
);

  fc_types_pkg::fc_ctrl_s                                          out_ctrl;
  fc_types_pkg::fc_ctrl_s core_ctrl [fc_params_pkg::GOBOU_CORE];
  logic                                                            img_we;
  logic [fc_params_pkg::MEMSIZE-1:0]                               img_addr;
  logic signed [fc_params_pkg::DWIDTH-1:0]                         img_wdata;
  logic                                                            mem_img_we;
  logic [fc_params_pkg::MEMSIZE-1:0]                               mem_img_addr;
  logic [fc_params_pkg::DWIDTH-1:0]                                mem_img_wdata;
  logic [fc_params_pkg::DWIDTH-1:0]                                img_rdata;
  logic [fc_params_pkg::GOBOU_CORE-1:0]                            mem_net_we;
  logic [fc_params_pkg::GOBOU_NETSIZE-1:0]                         mem_net_addr;
  logic [fc_params_pkg::GOBOU_CORE-1:0][fc_params_pkg::DWIDTH-1:0] net_rdata;
  logic [fc_params_pkg::GOBOU_CORE-1:0][fc_params_pkg::DWIDTH-1:0] core_result;
  logic [fc_params_pkg::DWIDTHLOG-1:0]                             q_qbits;
  logic                                                            q_bias_en;
  logic                                                            q_relu_en;
  logic                                                            breg_we;
  logic                                                            serial_we;
  logic signed [fc_params_pkg::DWIDTH-1:0]                         out_wdata;

  // all lanes share one timing so lane 0 speaks for them
  fc_ctrl ctrl0 (
    .clk          (clk),
    .xrst         (xrst),
    .in_ctrl      (core_ctrl[0]),
    .req          (req),
    .net_sel      (net_sel),
    .net_we       (net_we),
    .net_addr     (net_addr),
    .in_offset    (in_offset),
    .out_offset   (out_offset),
    .net_offset   (net_offset),
    .qbits        (qbits),
    .total_out    (total_out),
    .total_in     (total_in),
    .bias_en      (bias_en),
    .relu_en      (relu_en),
    .out_wdata    (out_wdata),
    .out_ctrl     (out_ctrl),
    .ack          (ack),
    .img_we       (img_we),
    .img_addr     (img_addr),
    .img_wdata    (img_wdata),
    .mem_net_we   (mem_net_we),
    .mem_net_addr (mem_net_addr),
    .q_qbits      (q_qbits),
    .q_bias_en    (q_bias_en),
    .q_relu_en    (q_relu_en),
    .breg_we      (breg_we),
    .serial_we    (serial_we)
  );

  // host owns the image memory while idle
  assign mem_img_we    = ack ? host_img_we    : img_we;
  assign mem_img_addr  = ack ? host_img_addr  : img_addr;
  assign mem_img_wdata = ack ? host_img_wdata : img_wdata;
  assign host_img_rdata = img_rdata;

  fc_ram #(
    .WIDTH    (fc_params_pkg::DWIDTH),
    .DEPTHLOG (fc_params_pkg::MEMSIZE)
  ) img_mem0 (
    .clk   (clk),
    .we    (mem_img_we),
    .addr  (mem_img_addr),
    .wdata (mem_img_wdata),
    .rdata (img_rdata)
  );

  for (genvar c = 0; c < fc_params_pkg::GOBOU_CORE; c++) begin : g_lane
    fc_ram #(
      .WIDTH    (fc_params_pkg::DWIDTH),
      .DEPTHLOG (fc_params_pkg::GOBOU_NETSIZE)
    ) net_mem (
      .clk   (clk),
      .we    (mem_net_we[c]),
      .addr  (mem_net_addr),
      .wdata (net_wdata),
      .rdata (net_rdata[c])
    );

    fc_mac_core core (
      .clk      (clk),
      .xrst     (xrst),
      .ctrl_in  (out_ctrl),
      .x        (img_rdata),
      .w        (net_rdata[c]),
      .breg_we  (breg_we),
      .qbits    (q_qbits),
      .bias_en  (q_bias_en),
      .relu_en  (q_relu_en),
      .ctrl_out (core_ctrl[c]),
      .result   (core_result[c])
    );
  end

  fc_serializer ser0 (
    .clk       (clk),
    .xrst      (xrst),
    .load      (serial_we),
    .lane_data (core_result),
    .out_wdata (out_wdata)
  );

endmodule

/* hdl/fc_types_pkg.sv */
package fc_types_pkg;

  // layer sequencer states
  typedef enum logic [2:0] {
    WAIT,
    SETUP,
    INPUT,
    BIAS,
    OUTPUT
  } fc_state_e;

  // strobes between the sequencer and the mac lanes
  typedef struct packed {
    // clear the accumulator / result ready on the way back
    logic start;
    // one product to accumulate
    logic valid;
    // end of the dot product
    logic stop;
  } fc_ctrl_s;

endpackage

/* test/fc_clkgen.sv */
`timescale 1ns/1ps

module fc_clkgen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset released a little after the edge
  initial begin
    xrst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 xrst = 1'b1;
  end

endmodule

/* test/fc_tb.sv */
`timescale 1ns/1ps

module fc_tb;

  typedef logic [fc_params_pkg::MEMSIZE-1:0]       img_addr_t;
  typedef logic [fc_params_pkg::GOBOU_NETSIZE-1:0] net_addr_t;
  typedef logic [fc_params_pkg::GOBOU_CORELOG-1:0] lane_t;
  typedef logic [fc_params_pkg::LWIDTH-1:0]        count_t;
  typedef logic [fc_params_pkg::DWIDTHLOG-1:0]     shift_t;
  typedef logic signed [fc_params_pkg::DWIDTH-1:0] word_t;

  logic      clk;
  logic      xrst;
  logic      host_img_we;
  img_addr_t host_img_addr;
  logic [fc_params_pkg::DWIDTH-1:0] host_img_wdata;
  logic [fc_params_pkg::DWIDTH-1:0] host_img_rdata;
  logic      net_we;
  lane_t     net_sel;
  net_addr_t net_addr;
  logic [fc_params_pkg::DWIDTH-1:0] net_wdata;
  img_addr_t in_offset;
  img_addr_t out_offset;
  net_addr_t net_offset;
  shift_t    qbits;
  count_t    total_in;
  count_t    total_out;
  logic      bias_en;
  logic      relu_en;
  logic      req;
  logic      ack;

  // copies of what the host wrote for the reference model
  word_t img_model [2**fc_params_pkg::MEMSIZE];
  word_t net_model [fc_params_pkg::GOBOU_CORE][2**fc_params_pkg::GOBOU_NETSIZE];

  int errors;
  int checks;
  int tests;
  int test_errors;
  int cycles;
  int cycle_limit;

  fc_clkgen #(.PERIOD(20), .RESET_CYCLES(16)) clkgen0 (.clk(clk), .xrst(xrst));

  fc_top dut0 (
    .clk            (clk),
    .xrst           (xrst),
    .host_img_we    (host_img_we),
    .host_img_addr  (host_img_addr),
    .host_img_wdata (host_img_wdata),
    .host_img_rdata (host_img_rdata),
    .net_we         (net_we),
    .net_sel        (net_sel),
    .net_addr       (net_addr),
    .net_wdata      (net_wdata),
    .in_offset      (in_offset),
    .out_offset     (out_offset),
    .net_offset     (net_offset),
    .qbits          (qbits),
    .total_in       (total_in),
    .total_out      (total_out),
    .bias_en        (bias_en),
    .relu_en        (relu_en),
    .req            (req),
    .ack            (ack)
  );

  // ==================================================
  // run limit
  // ==================================================

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // layer run plus host loads and readback
  function automatic int layer_budget(int tin, int tout, int img_words);
    int iters;
    iters = (tout + fc_params_pkg::GOBOU_CORE - 1) / fc_params_pkg::GOBOU_CORE;
    return iters * (tin + 10 + fc_params_pkg::SETUP_TIME)
         + iters * fc_params_pkg::GOBOU_CORE * (tin + 1) + img_words + tout + 20;
  endfunction

  // ==================================================
  // host side helpers
  // ==================================================

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // uniform in -span .. span
  function automatic word_t rand_word(int span);
    int v;
    v = int'($urandom_range(2 * span)) - span;
    return word_t'(v);
  endfunction

  task automatic check_eq(string name, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic host_write(int addr, word_t data);
    host_img_we    = 1'b1;
    host_img_addr  = img_addr_t'(addr);
    host_img_wdata = data;
    next_cycle();
    host_img_we    = 1'b0;
  endtask

  task automatic host_read(int addr, output word_t data);
    host_img_addr = img_addr_t'(addr);
    next_cycle();
    data = word_t'(host_img_rdata);
  endtask

  task automatic net_write(int lane, int addr, word_t data);
    net_we    = 1'b1;
    net_sel   = lane_t'(lane);
    net_addr  = net_addr_t'(addr);
    net_wdata = data;
    next_cycle();
    net_we    = 1'b0;
  endtask

  task automatic set_layer(int tin, int tout, int qb, bit b, bit r,
                           int in_off, int out_off, int net_off);
    total_in   = count_t'(tin);
    total_out  = count_t'(tout);
    qbits      = shift_t'(qb);
    bias_en    = b;
    relu_en    = r;
    in_offset  = img_addr_t'(in_off);
    out_offset = img_addr_t'(out_off);
    net_offset = net_addr_t'(net_off);
  endtask

  // mode 0 signed random, 1 non-negative random, 2 largest positive
  task automatic load_inputs(int lo, int count, int span, int mode);
    word_t v;
    for (int a = lo; a < lo + count; a++) begin
      case (mode)
        1: v = word_t'($urandom_range(span));
        2: v = word_t'(32767);
        default: v = rand_word(span);
      endcase
      img_model[a] = v;
      host_write(a, v);
    end
  endtask

  // mode 1 negative weights, mode 2 extreme weights of opposite sign per lane pair
  task automatic load_weights(int mode);
    int iters;
    int a;
    word_t v;
    iters = (int'(total_out) + fc_params_pkg::GOBOU_CORE - 1) / fc_params_pkg::GOBOU_CORE;
    for (int k = 0; k < iters; k++) begin
      for (int c = 0; c < fc_params_pkg::GOBOU_CORE; c++) begin
        for (int i = 0; i <= int'(total_in); i++) begin
          a = int'(net_offset) + k * (int'(total_in) + 1) + i;
          case (mode)
            1: v = (i == int'(total_in)) ? rand_word(300)
                                         : word_t'(-1 - int'($urandom_range(199)));
            2: v = (c < 2) ? word_t'(32767) : word_t'(-32768);
            default: v = rand_word(300);
          endcase
          net_model[c][a] = v;
          net_write(c, a, v);
        end
      end
    end
  endtask

  // dot product, bias, relu, shift, saturate
  function automatic int model_out(int n);
    int k;
    int c;
    int base;
    longint acc;
    k    = n / fc_params_pkg::GOBOU_CORE;
    c    = n % fc_params_pkg::GOBOU_CORE;
    base = int'(net_offset) + k * (int'(total_in) + 1);
    acc  = 0;
    for (int i = 0; i < int'(total_in); i++) begin
      acc += longint'(img_model[int'(in_offset) + i]) * longint'(net_model[c][base + i]);
    end
    if (bias_en) begin
      acc += longint'(net_model[c][base + int'(total_in)]);
    end
    if (relu_en && acc < 0) begin
      acc = 0;
    end
    acc = acc >>> qbits;
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    return int'(acc);
  endfunction

  // extra_req_delay > 0 sends a second req with altered parameters mid-run
  task automatic run_layer(int extra_req_delay);
    check_eq("ack", int'(ack), 1);
    req = 1'b1;
    next_cycle();
    req = 1'b0;
    check_eq("ack", int'(ack), 0);
    if (extra_req_delay > 0) begin
      repeat (extra_req_delay) next_cycle();
      // a capture of these would move and rescale the outputs
      qbits      = qbits + 1'b1;
      out_offset = out_offset + img_addr_t'(8);
      req        = 1'b1;
      next_cycle();
      req        = 1'b0;
      qbits      = qbits - 1'b1;
      out_offset = out_offset - img_addr_t'(8);
    end
    while (ack !== 1'b1) begin
      next_cycle();
    end
  endtask

  task automatic check_outputs();
    word_t v;
    int a;
    for (int n = 0; n < int'(total_out); n++) begin
      a = int'(out_offset) + n;
      host_read(a, v);
      check_eq($sformatf("img_mem[%0d]", a), int'(v), model_out(n));
    end
  endtask

  task automatic report_test(string name);
    tests++;
    $display("test %-14s %s", name, (errors == test_errors) ? "ok" : "mismatches");
    test_errors = errors;
  endtask

  // ==================================================
  // directed tests
  // ==================================================

  task automatic test_single_batch();
    set_layer(8, 4, 4, 1'b1, 1'b1, 0, 64, 0);
    load_inputs(0, 8, 200, 0);
    load_weights(0);
    run_layer(0);
    check_outputs();
    report_test("single_batch");
  endtask

  task automatic test_multi_batch();
    set_layer(6, 12, 3, 1'b1, 1'b0, 0, 100, 0);
    load_inputs(0, 6, 200, 0);
    load_weights(0);
    run_layer(0);
    check_outputs();
    report_test("multi_batch");
  endtask

  task automatic test_linear_path();
    set_layer(8, 4, 2, 1'b0, 1'b0, 16, 64, 0);
    load_inputs(16, 8, 200, 1);
    load_weights(1);
    run_layer(0);
    check_outputs();
    report_test("linear_path");
  endtask

  task automatic test_saturation();
    set_layer(8, 4, 15, 1'b1, 1'b0, 0, 64, 0);
    load_inputs(0, 8, 0, 2);
    load_weights(2);
    run_layer(0);
    check_outputs();
    report_test("saturation");
  endtask

  task automatic test_offsets();
    word_t v;
    set_layer(8, 8, 5, 1'b1, 1'b1, 200, 300, 50);
    // large words around the input window
    load_inputs(192, 8, 30000, 0);
    load_inputs(208, 8, 30000, 0);
    load_inputs(200, 8, 200, 0);
    load_inputs(290, 10, 30000, 0);
    load_weights(0);
    run_layer(0);
    check_outputs();
    for (int a = 290; a < 300; a++) begin
      host_read(a, v);
      check_eq($sformatf("img_mem[%0d]", a), int'(v), int'(img_model[a]));
    end
    report_test("offsets");
  endtask

  task automatic test_repeated_req();
    set_layer(5, 8, 2, 1'b1, 1'b0, 40, 500, 100);
    load_inputs(40, 5, 200, 0);
    load_weights(0);
    run_layer(3);
    check_outputs();
    report_test("repeated_req");
  endtask

  initial begin
    host_img_we    = 1'b0;
    host_img_addr  = '0;
    host_img_wdata = '0;
    net_we         = 1'b0;
    net_sel        = '0;
    net_addr       = '0;
    net_wdata      = '0;
    req            = 1'b0;
    set_layer(0, 0, 0, 1'b0, 1'b0, 0, 0, 0);
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    cycles      = 0;
    cycle_limit = 16 + 100
                + layer_budget(8, 4, 8) + layer_budget(6, 12, 6)
                + layer_budget(8, 4, 8) + layer_budget(8, 4, 8)
                + layer_budget(8, 8, 44) + layer_budget(5, 8, 5);
    void'($urandom(32'h945fe949));

    wait (xrst === 1'b1);
    next_cycle();

    test_single_batch();
    test_multi_batch();
    test_linear_path();
    test_saturation();
    test_offsets();
    test_repeated_req();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
